/* sim.f */
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/mips_pipe_top.sv
verif/tb_clk_gen.sv
verif/mips_pipe_sva.sv
verif/mips_pipe_tb.sv

/* Bender.yml */
package:
  name: mips_pipe

sources:
  - files:
      - src/cpu_isa_pkg.sv
      - src/cpu_pipe_pkg.sv
      - src/fetch_stage.sv
      - src/reg_file.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/mem_stage.sv
      - src/mips_pipe_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/mips_pipe_sva.sv
      - verif/mips_pipe_tb.sv

/* verif/mips_pipe_tb.sv */
module mips_pipe_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int prog_depth = 64;
  localparam int max_waits  = 3;

  typedef struct packed {
    cpu_isa_pkg::reg_idx_t rd;
    cpu_isa_pkg::word_t    value;
  } reg_write_t;

  typedef struct packed {
    cpu_isa_pkg::word_t adr;
    cpu_isa_pkg::word_t data;
  } store_t;

  logic                  clk;
  logic                  rst;
  cpu_isa_pkg::pc_t      imem_addr;
  cpu_isa_pkg::word_t    imem_data;
  cpu_pipe_pkg::wb_req_t wb_req;
  cpu_isa_pkg::word_t    wb_dat_r = '0;
  logic                  wb_ack = 1'b0;
  cpu_pipe_pkg::retire_t retire;

  cpu_isa_pkg::word_t prog [prog_depth];
  cpu_isa_pkg::word_t data_mem [cpu_isa_pkg::word_t];
  reg_write_t         exp_writes [$];
  store_t             exp_stores [$];
  int                 seed = 32'h737e_e53e;
  int                 waits_left;
  logic               bus_busy = 1'b0;
  logic               store_seen = 1'b0;
  int                 n_exec;
  int                 limit;
  int                 cycles;

  tb_clk_gen clk_gen_i (
    .clk(clk),
    .rst(rst)
  );

  mips_pipe_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .wb_req   (wb_req),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .retire   (retire)
  );

  assign imem_data = prog[imem_addr[5:0]];   // combinational rom

  ////////////////////////////////////////////////////////////
  // instruction encoding and program
  ////////////////////////////////////////////////////////////

  function automatic cpu_isa_pkg::word_t encode_r(cpu_isa_pkg::funct_t fn, int rd, int rs,
                                                  int rt, int shamt);
    return {cpu_isa_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
  endfunction

  function automatic cpu_isa_pkg::word_t encode_i(cpu_isa_pkg::opcode_t op, int rt, int rs,
                                                  int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic cpu_isa_pkg::word_t encode_j(int target);
    return {cpu_isa_pkg::op_j, 26'(target)};
  endfunction

  task automatic load_program();
    for (int i = 0; i < prog_depth; i++) begin
      prog[i] = encode_j(i);   // unused words spin in place
    end
    // dependent alu chains
    prog[0]  = encode_r(cpu_isa_pkg::fn_add, 1, 2, 3, 0);
    prog[1]  = encode_r(cpu_isa_pkg::fn_sub, 4, 1, 5, 0);
    prog[2]  = encode_r(cpu_isa_pkg::fn_mul, 6, 1, 7, 0);
    prog[3]  = encode_r(cpu_isa_pkg::fn_sll, 8, 6, 0, 3);
    prog[4]  = encode_r(cpu_isa_pkg::fn_srl, 9, 8, 0, 2);
    prog[5]  = encode_r(cpu_isa_pkg::fn_and, 10, 9, 8, 0);
    prog[6]  = encode_r(cpu_isa_pkg::fn_or, 11, 10, 9, 0);
    prog[7]  = encode_r(cpu_isa_pkg::fn_sub, 13, 4, 11, 0);
    prog[8]  = encode_r(cpu_isa_pkg::fn_slt, 12, 13, 2, 0);
    prog[9]  = encode_r(cpu_isa_pkg::fn_slt, 14, 2, 13, 0);
    // load-use, then store and reload
    prog[10] = encode_i(cpu_isa_pkg::op_addi, 15, 0, 100);
    prog[11] = encode_i(cpu_isa_pkg::op_lw, 16, 15, 4);
    prog[12] = encode_r(cpu_isa_pkg::fn_add, 17, 16, 1, 0);
    prog[13] = encode_i(cpu_isa_pkg::op_addi, 18, 17, -3);
    prog[14] = encode_i(cpu_isa_pkg::op_sw, 18, 15, 0);
    prog[15] = encode_i(cpu_isa_pkg::op_lw, 19, 15, 0);
    prog[16] = encode_i(cpu_isa_pkg::op_lw, 20, 15, 1);
    // branches and jumps, skipped words must never show up
    prog[17] = encode_i(cpu_isa_pkg::op_beq, 18, 19, 2);
    prog[18] = encode_i(cpu_isa_pkg::op_addi, 21, 0, 1);
    prog[19] = encode_i(cpu_isa_pkg::op_sw, 21, 0, 5);
    prog[20] = encode_i(cpu_isa_pkg::op_beq, 2, 1, 3);
    prog[21] = encode_r(cpu_isa_pkg::fn_add, 22, 20, 19, 0);
    prog[22] = encode_i(cpu_isa_pkg::op_beq, 22, 22, 1);
    prog[23] = encode_i(cpu_isa_pkg::op_addi, 23, 0, 7);
    prog[24] = encode_j(27);
    prog[25] = encode_i(cpu_isa_pkg::op_addi, 23, 0, 9);
    prog[26] = encode_i(cpu_isa_pkg::op_sw, 23, 0, 6);
    prog[27] = encode_r(cpu_isa_pkg::fn_or, 25, 22, 16, 0);
    prog[28] = encode_i(cpu_isa_pkg::op_addi, 0, 0, -1);   // r0 is a plain register
    prog[29] = encode_i(cpu_isa_pkg::op_sw, 0, 15, 2);
    prog[30] = encode_r(cpu_isa_pkg::fn_add, 26, 0, 0, 0);
    prog[31] = encode_j(31);
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // runs the program in order, returns instructions executed
  function automatic int run_model();
    cpu_isa_pkg::word_t regs [cpu_isa_pkg::num_regs];
    cpu_isa_pkg::word_t mem [cpu_isa_pkg::word_t];
    cpu_isa_pkg::word_t instr;
    cpu_isa_pkg::word_t a;
    cpu_isa_pkg::word_t b;
    cpu_isa_pkg::word_t imm;
    cpu_isa_pkg::word_t adr;
    cpu_isa_pkg::word_t value;
    cpu_isa_pkg::pc_t   pc;
    cpu_isa_pkg::pc_t   next_pc;
    logic [4:0]         dest;
    logic               writes;
    logic               finished;
    reg_write_t         wr;
    store_t             st;
    int                 count;
    for (int i = 0; i < cpu_isa_pkg::num_regs; i++) begin
      regs[i] = cpu_isa_pkg::word_t'(i);
    end
    pc       = '0;
    count    = 0;
    finished = 1'b0;
    while (!finished && count < 1000) begin
      instr   = prog[pc[5:0]];
      a       = regs[instr[25:21]];
      b       = regs[instr[20:16]];
      imm     = {{16{instr[15]}}, instr[15:0]};
      next_pc = pc + 1;
      writes  = 1'b0;
      dest    = instr[20:16];
      value   = '0;
      count++;
      case (instr[31:26])
        cpu_isa_pkg::op_rtype: begin
          writes = 1'b1;
          dest   = instr[15:11];
          case (instr[5:0])
            cpu_isa_pkg::fn_sub: value = a - b;
            cpu_isa_pkg::fn_mul: value = a * b;
            cpu_isa_pkg::fn_srl: value = a >> instr[10:6];   // rs field is shifted
            cpu_isa_pkg::fn_sll: value = a << instr[10:6];
            cpu_isa_pkg::fn_and: value = a & b;
            cpu_isa_pkg::fn_or:  value = a | b;
            cpu_isa_pkg::fn_slt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:             value = a + b;
          endcase
        end
        cpu_isa_pkg::op_addi: begin
          writes = 1'b1;
          value  = a + imm;
        end
        cpu_isa_pkg::op_lw: begin
          adr    = a + imm;
          writes = 1'b1;
          value  = mem.exists(adr) ? mem[adr] : adr;
        end
        cpu_isa_pkg::op_sw: begin
          adr      = a + imm;
          mem[adr] = b;
          st.adr   = adr;
          st.data  = b;
          exp_stores.push_back(st);
        end
        cpu_isa_pkg::op_beq: begin
          if (a == b) begin
            next_pc = next_pc + imm;
          end
        end
        cpu_isa_pkg::op_j: begin
          next_pc  = cpu_isa_pkg::pc_t'(instr[25:0]);
          finished = (next_pc == pc);   // jump to itself ends the program
        end
        default: ;
      endcase
      if (writes) begin
        regs[dest] = value;
        wr.rd      = dest;
        wr.value   = value;
        exp_writes.push_back(wr);
      end
      pc = next_pc;
    end
    return count;
  endfunction

  ////////////////////////////////////////////////////////////
  // wishbone memory model
  ////////////////////////////////////////////////////////////

  function automatic cpu_isa_pkg::word_t read_data_word(cpu_isa_pkg::word_t adr);
    return data_mem.exists(adr) ? data_mem[adr] : adr;
  endfunction

  always @(negedge clk) begin
    if (rst) begin
      wb_ack   = 1'b0;
      bus_busy = 1'b0;
    end else if (wb_ack) begin
      wb_ack   = 1'b0;   // single cycle ack
      bus_busy = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!bus_busy) begin
        bus_busy   = 1'b1;
        waits_left = $unsigned($random(seed)) % (max_waits + 1);
      end
      if (waits_left == 0) begin
        if (wb_req.we) begin
          data_mem[wb_req.adr] = wb_req.dat_w;
        end else begin
          wb_dat_r = read_data_word(wb_req.adr);
        end
        wb_ack = 1'b1;
      end else begin
        waits_left--;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input cpu_isa_pkg::word_t got,
                             input cpu_isa_pkg::word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // outputs only change at the rising edge
  always @(negedge clk) begin
    if (!rst) begin
      if (retire.valid) begin
        if (exp_writes.size() == 0) begin
          stop_run($sformatf("extra register write to r%0d at %0d ns", retire.rd, $time));
        end else begin
          check_value("retire rd", cpu_isa_pkg::word_t'(retire.rd), exp_writes[0].rd);
          check_value("retire value", retire.value, exp_writes[0].value);
          void'(exp_writes.pop_front());
        end
      end
      if (!wb_req.cyc) begin
        store_seen = 1'b0;
      end else if (wb_req.we && !store_seen) begin
        store_seen = 1'b1;   // one check per transfer
        if (exp_stores.size() == 0) begin
          stop_run($sformatf("extra store to %h at %0d ns", wb_req.adr, $time));
        end else begin
          check_value("store adr", wb_req.adr, exp_stores[0].adr);
          check_value("store data", wb_req.dat_w, exp_stores[0].data);
          void'(exp_stores.pop_front());
        end
      end
    end
  end

  initial begin
    load_program();
    n_exec = run_model();
    limit  = n_exec * (max_waits + 4) + 50;
    cycles = 0;
    wait (!rst);
    while ((exp_writes.size() != 0 || exp_stores.size() != 0) && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_writes.size() != 0 || exp_stores.size() != 0) begin
      stop_run($sformatf("timeout after %0d cycles, %0d writes and %0d stores missing",
                         cycles, exp_writes.size(), exp_stores.size()));
    end else begin
      repeat (10) @(negedge clk);   // late extra retires would still fail
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* verif/mips_pipe_sva.sv */
module mips_pipe_sva (
  input logic                  clk,
  input logic                  rst,
  input cpu_isa_pkg::pc_t      imem_addr,
  input cpu_pipe_pkg::wb_req_t wb_req,
  input logic                  wb_ack,
  input cpu_pipe_pkg::retire_t retire
);

  timeunit 1ns;
  timeprecision 1ps;

  // first cycle out of reset is quiet
  reset_quiet: assert property (@(posedge clk)
    rst |=> !wb_req.cyc && !retire.valid && imem_addr == '0)
    else $error("bus request, retire or nonzero pc right after reset");

  stb_with_cyc: assert property (@(posedge clk) disable iff (rst)
    wb_req.stb |-> wb_req.cyc)
    else $error("stb raised without cyc");

  // classic cycle, request frozen until ack
  held_until_ack: assert property (@(posedge clk) disable iff (rst)
    wb_req.stb && !wb_ack |=> wb_req.stb && $stable(wb_req.we) &&
                              $stable(wb_req.adr) && $stable(wb_req.dat_w))
    else $error("bus request changed before ack");

  idle_after_ack: assert property (@(posedge clk) disable iff (rst)
    wb_req.stb && wb_ack |=> !wb_req.cyc)
    else $error("cyc not dropped after ack");

  retire_known: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> !$isunknown(retire.rd) && !$isunknown(retire.value))
    else $error("retire carries unknown bits");

endmodule

bind mips_pipe_top mips_pipe_sva sva_i (
  .clk      (clk),
  .rst      (rst),
  .imem_addr(imem_addr),
  .wb_req   (wb_req),
  .wb_ack   (wb_ack),
  .retire   (retire)
);

/* verif/tb_clk_gen.sv */
module tb_clk_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int  reset_cycles = 8;
  localparam time half_period  = 10ns;   // 20 ns clock

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release on a falling edge, like every other input
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* src/mips_pipe_top.sv */
module mips_pipe_top (
  input  logic                  clk,
  input  logic                  rst,
  output cpu_isa_pkg::pc_t      imem_addr,
  input  cpu_isa_pkg::word_t    imem_data,
  output cpu_pipe_pkg::wb_req_t wb_req,
  input  cpu_isa_pkg::word_t    wb_dat_r,
  input  logic                  wb_ack,
  output cpu_pipe_pkg::retire_t retire
);

  cpu_pipe_pkg::if_id_t  if_id;
  cpu_pipe_pkg::id_ex_t  id_ex;
  cpu_pipe_pkg::ex_mem_t ex_fwd;
  cpu_pipe_pkg::retire_t wb_fwd;
  cpu_isa_pkg::reg_idx_t rs;
  cpu_isa_pkg::reg_idx_t rt;
  cpu_isa_pkg::word_t    rs_data;
  cpu_isa_pkg::word_t    rt_data;
  cpu_isa_pkg::pc_t      branch_target;
  logic                  load_stall;
  logic                  mem_hold;
  logic                  branch_taken;

  assign retire = wb_fwd;   // every register write is visible here

  ////////////////////////////////////////////////////////////
  // fetch, decode, register file
  ////////////////////////////////////////////////////////////

  fetch_stage fetch_i (
    .clk          (clk),
    .rst          (rst),
    .imem_data    (imem_data),
    .load_stall   (load_stall),
    .mem_hold     (mem_hold),
    .branch_taken (branch_taken),
    .branch_target(branch_target),
    .imem_addr    (imem_addr),
    .if_id        (if_id)
  );

  reg_file rf_i (
    .clk    (clk),
    .rst    (rst),
    .rs     (rs),
    .rt     (rt),
    .wb_fwd (wb_fwd),
    .rs_data(rs_data),
    .rt_data(rt_data)
  );

  decode_stage decode_i (
    .clk          (clk),
    .rst          (rst),
    .if_id        (if_id),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .ex_fwd       (ex_fwd),
    .wb_fwd       (wb_fwd),
    .mem_hold     (mem_hold),
    .rs           (rs),
    .rt           (rt),
    .id_ex        (id_ex),
    .load_stall   (load_stall),
    .branch_taken (branch_taken),
    .branch_target(branch_target)
  );

  ////////////////////////////////////////////////////////////
  // execute, memory
  ////////////////////////////////////////////////////////////

  execute_stage exec_i (
    .clk     (clk),
    .rst     (rst),
    .id_ex   (id_ex),
    .wb_fwd  (wb_fwd),
    .mem_hold(mem_hold),
    .ex_fwd  (ex_fwd)
  );

  mem_stage mem_i (
    .clk     (clk),
    .rst     (rst),
    .ex_fwd  (ex_fwd),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack),
    .wb_req  (wb_req),
    .mem_hold(mem_hold),
    .wb_fwd  (wb_fwd)
  );

endmodule

/* src/mem_stage.sv */
module mem_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  cpu_pipe_pkg::ex_mem_t ex_fwd,
  input  cpu_isa_pkg::word_t    wb_dat_r,
  input  logic                  wb_ack,
  output cpu_pipe_pkg::wb_req_t wb_req,
  output logic                  mem_hold,
  output cpu_pipe_pkg::retire_t wb_fwd
);

  typedef enum logic {
    mem_idle,
    mem_busy
  } mem_state_e;

  mem_state_e state_q;
  logic       mem_op;
  logic       gap_q;    // ack seen last cycle, bus stays quiet once
  logic       issue;
  logic       done;

  assign mem_op   = ex_fwd.mem_read || ex_fwd.mem_write;
  assign issue    = (state_q == mem_busy) || (mem_op && !gap_q);
  assign done     = issue && wb_ack;
  assign mem_hold = mem_op && !done;   // freezes every stage register

  // address and data come straight from the held ex/mem register
  assign wb_req.cyc   = issue;
  assign wb_req.stb   = issue;
  assign wb_req.we    = ex_fwd.mem_write;
  assign wb_req.adr   = ex_fwd.result;
  assign wb_req.dat_w = ex_fwd.store_data;

  ////////////////////////////////////////////////////////////
  // bus state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= mem_idle;
      gap_q   <= 1'b0;
    end else begin
      gap_q <= done;
      case (state_q)
        mem_idle: begin
          if (issue && !wb_ack) begin
            state_q <= mem_busy;   // wait states
          end
        end
        mem_busy: begin
          if (wb_ack) begin
            state_q <= mem_idle;
          end
        end
        default: state_q <= mem_idle;
      endcase
    end
  end

  // memory/writeback register, nothing leaves while the bus waits
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_fwd.valid <= 1'b0;
    end else begin
      wb_fwd.valid <= ex_fwd.reg_write && !mem_hold;
      wb_fwd.rd    <= ex_fwd.dest;
      wb_fwd.value <= ex_fwd.mem_read ? wb_dat_r : ex_fwd.result;
    end
  end

endmodule

/* src/execute_stage.sv */
module execute_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  cpu_pipe_pkg::id_ex_t  id_ex,
  input  cpu_pipe_pkg::retire_t wb_fwd,
  input  logic                  mem_hold,
  output cpu_pipe_pkg::ex_mem_t ex_fwd
);

  cpu_isa_pkg::word_t   fwd_a;
  cpu_isa_pkg::word_t   fwd_b;
  cpu_isa_pkg::word_t   alu_b;
  cpu_isa_pkg::word_t   result;
  cpu_isa_pkg::alu_op_e alu_op;
  logic                 is_rtype;

  // newest producer wins; a load in memory has no result yet
  function automatic cpu_isa_pkg::word_t fwd_sel(
    input cpu_isa_pkg::reg_idx_t idx,
    input cpu_isa_pkg::word_t    held
  );
    if (ex_fwd.reg_write && !ex_fwd.mem_read && ex_fwd.dest == idx) begin
      return ex_fwd.result;
    end else if (wb_fwd.valid && wb_fwd.rd == idx) begin
      return wb_fwd.value;
    end
    return held;
  endfunction

  assign fwd_a    = fwd_sel(id_ex.rs, id_ex.op_a);
  assign fwd_b    = fwd_sel(id_ex.rt, id_ex.op_b);
  assign alu_b    = id_ex.ctrl.alu_src_imm ? id_ex.imm : fwd_b;
  assign is_rtype = id_ex.ctrl.reg_write && !id_ex.ctrl.alu_src_imm;

  always_comb begin
    alu_op = id_ex.ctrl.alu_op;
    if (is_rtype) begin
      case (cpu_isa_pkg::funct_t'(id_ex.imm[5:0]))
        cpu_isa_pkg::fn_add: alu_op = cpu_isa_pkg::alu_add;
        cpu_isa_pkg::fn_sub: alu_op = cpu_isa_pkg::alu_sub;
        cpu_isa_pkg::fn_mul: alu_op = cpu_isa_pkg::alu_mul;
        cpu_isa_pkg::fn_srl: alu_op = cpu_isa_pkg::alu_srl;
        cpu_isa_pkg::fn_sll: alu_op = cpu_isa_pkg::alu_sll;
        cpu_isa_pkg::fn_and: alu_op = cpu_isa_pkg::alu_and;
        cpu_isa_pkg::fn_or:  alu_op = cpu_isa_pkg::alu_or;
        cpu_isa_pkg::fn_slt: alu_op = cpu_isa_pkg::alu_slt;
        default:             alu_op = cpu_isa_pkg::alu_add;
      endcase
    end
  end

  always_comb begin
    case (alu_op)
      cpu_isa_pkg::alu_add: result = fwd_a + alu_b;
      cpu_isa_pkg::alu_sub: result = fwd_a - alu_b;
      cpu_isa_pkg::alu_mul: result = fwd_a * alu_b;         // low word only
      cpu_isa_pkg::alu_srl: result = fwd_a >> id_ex.shamt;  // shifts rs
      cpu_isa_pkg::alu_sll: result = fwd_a << id_ex.shamt;
      cpu_isa_pkg::alu_and: result = fwd_a & alu_b;
      cpu_isa_pkg::alu_or:  result = fwd_a | alu_b;
      default:              result = {31'd0, $signed(fwd_a) < $signed(alu_b)};
    endcase
  end

  // execute/memory register
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_fwd.reg_write <= 1'b0;
      ex_fwd.mem_read  <= 1'b0;
      ex_fwd.mem_write <= 1'b0;
    end else if (!mem_hold) begin
      ex_fwd.reg_write  <= id_ex.ctrl.reg_write;
      ex_fwd.mem_read   <= id_ex.ctrl.mem_read;
      ex_fwd.mem_write  <= id_ex.ctrl.mem_write;
      ex_fwd.dest       <= id_ex.dest;
      ex_fwd.result     <= result;
      ex_fwd.store_data <= fwd_b;
    end
  end

endmodule

/* src/decode_stage.sv */
module decode_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  cpu_pipe_pkg::if_id_t  if_id,
  input  cpu_isa_pkg::word_t    rs_data,
  input  cpu_isa_pkg::word_t    rt_data,
  input  cpu_pipe_pkg::ex_mem_t ex_fwd,
  input  cpu_pipe_pkg::retire_t wb_fwd,
  input  logic                  mem_hold,
  output cpu_isa_pkg::reg_idx_t rs,
  output cpu_isa_pkg::reg_idx_t rt,
  output cpu_pipe_pkg::id_ex_t  id_ex,
  output logic                  load_stall,
  output logic                  branch_taken,
  output cpu_isa_pkg::pc_t      branch_target
);

  cpu_isa_pkg::opcode_t  opcode;
  cpu_isa_pkg::reg_idx_t rd;
  cpu_isa_pkg::reg_idx_t dest;
  cpu_isa_pkg::word_t    imm_sext;
  cpu_isa_pkg::word_t    cmp_a;
  cpu_isa_pkg::word_t    cmp_b;
  cpu_pipe_pkg::ctrl_t   ctrl;
  logic                  is_beq;
  logic                  ex_load_hit;
  logic                  ex_write_hit;
  logic                  mem_load_hit;

  assign opcode   = if_id.instr[31:26];
  assign rs       = if_id.instr[25:21];
  assign rt       = if_id.instr[20:16];
  assign rd       = if_id.instr[15:11];
  assign imm_sext = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
  assign is_beq   = (opcode == cpu_isa_pkg::op_beq);

  ////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl = '0;                        // unknown opcodes and beq pass as nops
    dest = rt;
    case (opcode)
      cpu_isa_pkg::op_rtype: begin
        ctrl.reg_write = 1'b1;        // alu op from funct, in execute
        dest           = rd;
      end
      cpu_isa_pkg::op_addi: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      cpu_isa_pkg::op_lw: begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      cpu_isa_pkg::op_sw: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // branch compare and hazards
  ////////////////////////////////////////////////////////////

  // wb values already come through the register file
  assign cmp_a = (ex_fwd.reg_write && !ex_fwd.mem_read && ex_fwd.dest == rs) ?
                 ex_fwd.result : rs_data;
  assign cmp_b = (ex_fwd.reg_write && !ex_fwd.mem_read && ex_fwd.dest == rt) ?
                 ex_fwd.result : rt_data;

  assign ex_load_hit  = id_ex.ctrl.mem_read && (id_ex.dest == rs || id_ex.dest == rt);
  // a beq can't see a result still in execute, nor load data still on the bus
  assign ex_write_hit = id_ex.ctrl.reg_write && (id_ex.dest == rs || id_ex.dest == rt);
  assign mem_load_hit = ex_fwd.mem_read && (ex_fwd.dest == rs || ex_fwd.dest == rt);

  assign load_stall    = if_id.valid &&
                         (ex_load_hit || (is_beq && (ex_write_hit || mem_load_hit)));
  assign branch_taken  = if_id.valid && is_beq && !load_stall && (cmp_a == cmp_b);
  assign branch_target = if_id.pc_next + imm_sext;

  // decode/execute register
  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex.ctrl <= '0;
    end else if (mem_hold) begin
      // the held instruction would miss a write that retires meanwhile
      if (wb_fwd.valid && wb_fwd.rd == id_ex.rs) begin
        id_ex.op_a <= wb_fwd.value;
      end
      if (wb_fwd.valid && wb_fwd.rd == id_ex.rt) begin
        id_ex.op_b <= wb_fwd.value;
      end
    end else if (!if_id.valid || load_stall) begin
      id_ex.ctrl <= '0;               // bubble
    end else begin
      id_ex.ctrl  <= ctrl;
      id_ex.rs    <= rs;
      id_ex.rt    <= rt;
      id_ex.dest  <= dest;
      id_ex.op_a  <= rs_data;
      id_ex.op_b  <= rt_data;
      id_ex.imm   <= imm_sext;
      id_ex.shamt <= if_id.instr[10:6];
    end
  end

endmodule

/* src/reg_file.sv */
module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  cpu_isa_pkg::reg_idx_t rs,
  input  cpu_isa_pkg::reg_idx_t rt,
  input  cpu_pipe_pkg::retire_t wb_fwd,
  output cpu_isa_pkg::word_t    rs_data,
  output cpu_isa_pkg::word_t    rt_data
);

  cpu_isa_pkg::word_t regs [cpu_isa_pkg::num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu_isa_pkg::num_regs; i++) begin
        regs[i] <= cpu_isa_pkg::word_t'(i);   // each register starts at its index
      end
    end else if (wb_fwd.valid) begin
      regs[wb_fwd.rd] <= wb_fwd.value;        // r0 is writable too
    end
  end

  // write-through, same cycle read sees the retiring value
  assign rs_data = (wb_fwd.valid && wb_fwd.rd == rs) ? wb_fwd.value : regs[rs];
  assign rt_data = (wb_fwd.valid && wb_fwd.rd == rt) ? wb_fwd.value : regs[rt];

endmodule

/* src/fetch_stage.sv */
module fetch_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_isa_pkg::word_t   imem_data,
  input  logic                 load_stall,
  input  logic                 mem_hold,
  input  logic                 branch_taken,
  input  cpu_isa_pkg::pc_t     branch_target,
  output cpu_isa_pkg::pc_t     imem_addr,
  output cpu_pipe_pkg::if_id_t if_id
);

  cpu_isa_pkg::pc_t pc_q;
  cpu_isa_pkg::pc_t pc_plus1;
  cpu_isa_pkg::pc_t jump_target;
  logic             is_jump;
  logic             advance;

  assign imem_addr   = pc_q;   // rom answers in the same cycle
  assign pc_plus1    = pc_q + 1'b1;
  assign is_jump     = (imem_data[31:26] == cpu_isa_pkg::op_j);
  assign jump_target = cpu_isa_pkg::pc_t'(imem_data[25:0]);   // zero extended
  assign advance     = !mem_hold && !load_stall;

  // next pc, a taken branch in decode beats a jump seen here
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else if (advance) begin
      if (branch_taken) begin
        pc_q <= branch_target;
      end else if (is_jump) begin
        pc_q <= jump_target;
      end else begin
        pc_q <= pc_plus1;
      end
    end
  end

  // fetch/decode register
  always_ff @(posedge clk) begin
    if (rst) begin
      if_id.valid <= 1'b0;
    end else if (advance) begin
      if_id.valid   <= !branch_taken && !is_jump;   // squashed slot or finished jump
      if_id.instr   <= imem_data;
      if_id.pc_next <= pc_plus1;
    end
  end

endmodule

/* src/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

  // decoded control, travels with the instruction into execute
  typedef struct packed {
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 alu_src_imm;   // b operand is the immediate
    cpu_isa_pkg::alu_op_e alu_op;
  } ctrl_t;

  // fetch -> decode
  typedef struct packed {
    logic               valid;
    cpu_isa_pkg::word_t instr;
    cpu_isa_pkg::pc_t   pc_next;   // branch base
  } if_id_t;

  // decode -> execute
  typedef struct packed {
    ctrl_t                 ctrl;
    cpu_isa_pkg::reg_idx_t rs;
    cpu_isa_pkg::reg_idx_t rt;
    cpu_isa_pkg::reg_idx_t dest;
    cpu_isa_pkg::word_t    op_a;
    cpu_isa_pkg::word_t    op_b;
    cpu_isa_pkg::word_t    imm;    // sign extended, low bits hold funct
    cpu_isa_pkg::shamt_t   shamt;
  } id_ex_t;

  // execute -> memory
  typedef struct packed {
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    cpu_isa_pkg::reg_idx_t dest;
    cpu_isa_pkg::word_t    result;      // also the bus word address
    cpu_isa_pkg::word_t    store_data;
  } ex_mem_t;

  // memory -> writeback, and the retire port
  typedef struct packed {
    logic                  valid;
    cpu_isa_pkg::reg_idx_t rd;
    cpu_isa_pkg::word_t    value;
  } retire_t;

  // wishbone classic master outputs
  typedef struct packed {
    logic               cyc;
    logic               stb;
    logic               we;
    cpu_isa_pkg::word_t adr;
    cpu_isa_pkg::word_t dat_w;
  } wb_req_t;

endpackage

/* src/cpu_isa_pkg.sv */
package cpu_isa_pkg;

  localparam int word_w    = 32;
  localparam int reg_idx_w = 5;
  localparam int pc_w      = 32;
  localparam int num_regs  = 2 ** reg_idx_w;

  typedef logic [word_w-1:0]    word_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [pc_w-1:0]      pc_t;      // counts words, not bytes
  typedef logic [5:0]           opcode_t;
  typedef logic [5:0]           funct_t;
  typedef logic [4:0]           shamt_t;

  ////////////////////////////////////////////////////////////
  // opcodes, instr[31:26]
  ////////////////////////////////////////////////////////////

  localparam opcode_t op_rtype = 6'd0;
  localparam opcode_t op_addi  = 6'd8;
  localparam opcode_t op_lw    = 6'd35;
  localparam opcode_t op_sw    = 6'd43;
  localparam opcode_t op_beq   = 6'd4;
  localparam opcode_t op_j     = 6'd2;

  ////////////////////////////////////////////////////////////
  // r-type function codes, instr[5:0]
  ////////////////////////////////////////////////////////////

  localparam funct_t fn_add = 6'd0;
  localparam funct_t fn_sub = 6'd1;
  localparam funct_t fn_mul = 6'd2;
  localparam funct_t fn_srl = 6'd3;
  localparam funct_t fn_sll = 6'd4;
  localparam funct_t fn_and = 6'd5;
  localparam funct_t fn_or  = 6'd6;
  localparam funct_t fn_slt = 6'd42;   // 0x2a

  // one code per operation
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_mul = 3'd2,
    alu_srl = 3'd3,
    alu_sll = 3'd4,
    alu_and = 3'd5,
    alu_or  = 3'd6,
    alu_slt = 3'd7
  } alu_op_e;

endpackage
